//--- sources.f
logic/usb_dfu_pkg.sv
logic/setup_req_if.sv
logic/setup_capture.sv
logic/ctrl_xfr_fsm.sv
logic/dfu_request_handler.sv
logic/reply_source.sv
logic/usb_dfu_ctrl_ep.sv
dv/usb_dfu_ctrl_ep_asserts.sv
dv/usb_dfu_ctrl_ep_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f sources.f \
		--top-module usb_dfu_ctrl_ep_tb -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

//--- dv/usb_dfu_ctrl_ep_tb.sv
`timescale 1ns/100ps
`default_nettype none

module usb_dfu_ctrl_ep_tb;

  logic       clk;
  logic       reset;
  logic       out_ep_req;
  logic       out_ep_grant;
  logic       out_ep_data_avail;
  logic       out_ep_setup;
  logic       out_ep_data_get;
  logic [7:0] out_ep_data;
  logic       out_ep_acked;
  logic       in_ep_req;
  logic       in_ep_grant;
  logic       in_ep_data_free;
  logic       in_ep_data_put;
  logic [7:0] in_ep_data;
  logic       in_ep_data_done;
  logic       in_ep_stall;
  logic       in_ep_acked;
  logic [6:0] dev_addr;
  logic [7:0] dfu_state;

  string test_name;
  int    errors;
  int    tests;
  int    test_start_errors;
  int    cycles;

  // reference model
  logic [7:0]  m_state;
  logic [7:0]  m_status;
  logic [15:0] m_base;
  logic [6:0]  m_addr;

  usb_dfu_ctrl_ep usb_dfu_ctrl_ep_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= 12000) begin // 40 transfers of up to 300 cycles
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_eq(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s: %s, %0d errors", test_name,
             (errors == test_start_errors) ? "ok" : "FAIL", errors - test_start_errors);
  endtask

  // a byte is taken on a granted cycle and shows on out_ep_data one cycle later
  task automatic send_out_bytes(input logic [7:0] pkt[$], input logic is_setup);
    int taken;
    taken = 0;
    @(negedge clk);
    check_eq("out_ep_req idle", 0, out_ep_req);
    out_ep_setup      = is_setup;
    out_ep_data_avail = 1'b1;
    out_ep_grant      = ($urandom % 4) != 0;
    while (taken < pkt.size()) begin
      @(negedge clk);
      check_eq("out_ep_req", 1, out_ep_req); // follows avail
      check_eq("out_ep_data_get", 1, out_ep_data_get);
      if (out_ep_grant) begin
        out_ep_data = pkt[taken];
        taken++;
      end
      if (taken == pkt.size()) begin
        out_ep_data_avail = 1'b0;
        out_ep_grant      = 1'b0;
        out_ep_setup      = 1'b0;
      end else begin
        out_ep_grant = ($urandom % 4) != 0;
      end
    end
  endtask

  task automatic send_setup(input logic [7:0] rt, input logic [7:0] breq,
                            input logic [15:0] value, input logic [15:0] length);
    logic [7:0] pkt[$];
    pkt = {rt, breq, value[7:0], value[15:8], 8'h00, 8'h00, length[7:0], length[15:8]};
    send_out_bytes(pkt, 1'b1);
  endtask

  task automatic pulse_ack(input logic is_in);
    if (is_in) in_ep_acked = 1'b1;
    else out_ep_acked = 1'b1;
    @(negedge clk);
    in_ep_acked  = 1'b0;
    out_ep_acked = 1'b0;
  endtask

  task automatic wait_data_done();
    int cyc;
    cyc = 0;
    #1;
    while (!in_ep_data_done && cyc < 300) begin
      @(negedge clk);
      #1;
      cyc++;
    end
    assert (in_ep_data_done) else begin
      $display("%s: in_ep_data_done never came", test_name);
      errors++;
    end
    @(negedge clk);
  endtask

  // DFU rules applied at the setup stage
  task automatic model_setup(input logic [7:0] rt, input logic [7:0] breq,
                             input logic [15:0] value, input logic [15:0] length);
    logic [9:0] code;
    code = {rt[6:5], breq};
    case (code)
      10'h101: begin
        if (m_state == 8'h02) begin
          if (length != 0) begin
            m_state = 8'h04;
            m_base  = value;
          end else begin
            m_state  = 8'h0a;
            m_status = 8'h03;
          end
        end else if (m_state != 8'h05) begin
          m_state  = 8'h0a;
          m_status = 8'h03;
        end else if (length == 0) begin
          m_state = 8'h06;
        end else if (value >= m_base + 16'd64) begin
          m_state  = 8'h0a;
          m_status = 8'h08;
        end else begin
          m_state = 8'h04;
        end
      end
      10'h103: begin
        if (m_state == 8'h03) m_state = 8'h05;
        else if (m_state == 8'h06) m_state = 8'h02;
      end
      10'h104: begin
        m_status = 8'h00;
        m_state  = 8'h02;
      end
      10'h106: m_state = 8'h02;
      default: ;
    endcase
  endtask

  task automatic in_request(input logic [7:0] rt, input logic [7:0] breq,
                            input logic [15:0] value, input logic [15:0] length,
                            output logic [7:0] got[$], output logic stalled);
    int   cyc;
    logic done;
    got     = {};
    stalled = 1'b0;
    done    = 1'b0;
    cyc     = 0;
    model_setup(rt, breq, value, length);
    send_setup(rt, breq, value, length);
    while (!done && !stalled && cyc < 300) begin
      in_ep_grant     = ($urandom % 4) != 0;
      in_ep_data_free = ($urandom % 4) != 0;
      #1;
      // request stays up from the first byte until the done cycle
      if (in_ep_data_put || got.size() > 0 || in_ep_stall) begin
        check_eq("in_ep_req", !in_ep_data_done && !in_ep_stall, in_ep_req);
      end
      if (in_ep_data_put && in_ep_grant) got.push_back(in_ep_data);
      if (in_ep_data_done) done = 1'b1;
      if (in_ep_stall) stalled = 1'b1;
      @(negedge clk);
      cyc++;
    end
    in_ep_grant     = 1'b0;
    in_ep_data_free = 1'b0;
    assert (done || stalled) else begin
      $display("%s: IN request ended with neither done nor stall", test_name);
      errors++;
    end
    if (done) begin
      pulse_ack(1'b1);
      pulse_ack(1'b0);
    end
  endtask

  task automatic out_request(input logic [7:0] rt, input logic [7:0] breq,
                             input logic [15:0] value, input logic [15:0] length);
    logic [7:0] data[$];
    data = {};
    model_setup(rt, breq, value, length);
    send_setup(rt, breq, value, length);
    if (length != 0) begin
      repeat (4) @(negedge clk); // FSM reaches data_out
      for (int i = 0; i < length; i++) data.push_back(8'($urandom));
      send_out_bytes(data, 1'b0);
      if (m_state == 8'h04) m_state = 8'h03; // end of data = write done
    end
    wait_data_done();
    check_eq("dev_addr before status", m_addr, dev_addr);
    pulse_ack(1'b1);
    if ({rt[6:5], breq} == 10'h005) m_addr = value[6:0];
  endtask

  task automatic check_status();
    logic [7:0] got[$];
    logic       stalled;
    logic [7:0] exp[6];
    in_request(8'ha1, 8'd3, 16'd0, 16'd6, got, stalled);
    exp = '{m_status, 8'd1, 8'd0, 8'd0, m_state, 8'd0};
    check_eq("status length", 6, got.size());
    for (int i = 0; i < 6 && i < got.size(); i++) check_eq("status byte", exp[i], got[i]);
    check_eq("dfu_state", m_state, dfu_state);
    in_request(8'ha1, 8'd5, 16'd0, 16'd1, got, stalled);
    check_eq("getstate length", 1, got.size());
    if (got.size() > 0) check_eq("getstate byte", m_state, got[0]);
  endtask

  task automatic check_descriptor(input logic [15:0] length);
    logic [7:0] got[$];
    logic       stalled;
    logic [7:0] table_bytes[18];
    int         exp_len;
    table_bytes = '{8'd18, 8'd1, 8'h00, 8'h01, 8'd0, 8'd0, 8'd0, 8'd32, 8'h50, 8'h1d,
                    8'h30, 8'h61, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1};
    exp_len = (length < 18) ? length : 18;
    in_request(8'h80, 8'd6, 16'h0100, length, got, stalled);
    check_eq("stall", 0, stalled);
    check_eq("descriptor length", exp_len, got.size());
    for (int i = 0; i < got.size() && i < 18; i++) begin
      check_eq("descriptor byte", table_bytes[i], got[i]);
    end
  endtask

  initial begin
    logic [7:0] got[$];
    logic       stalled;
    logic [6:0] addr;
    int         nblk;
    void'($urandom(32'hd09507c4));
    errors = 0;
    tests  = 0;
    cycles = 0;
    reset             = 1'b1;
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = 8'h00;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b0;
    in_ep_data_free   = 1'b0;
    in_ep_acked       = 1'b0;
    m_state  = 8'h02;
    m_status = 8'h00;
    m_base   = 16'd0;
    m_addr   = 7'd0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("device_descriptor");
    check_descriptor(16'($urandom_range(1, 17))); // shorter than the table
    repeat (2) check_descriptor(16'($urandom_range(1, 64)));
    end_test();

    start_test("bad_descriptor");
    in_request(8'h80, 8'd6, 16'h0200, 16'd9, got, stalled); // configuration type
    check_eq("stall", 1, stalled);
    check_eq("bytes sent", 0, got.size());
    check_descriptor(16'd18);
    end_test();

    start_test("set_address");
    addr = 7'($urandom_range(1, 127));
    out_request(8'h00, 8'd5, {9'd0, addr}, 16'd0);
    #1;
    check_eq("dev_addr after status", addr, dev_addr);
    out_request(8'h00, 8'd9, 16'd1, 16'd0);
    end_test();

    start_test("download");
    nblk = $urandom_range(1, 4);
    for (int i = 0; i < nblk; i++) begin
      out_request(8'h21, 8'd1, 16'(i), 16'($urandom_range(1, 16)));
      check_status();
    end
    out_request(8'h21, 8'd1, 16'(nblk), 16'd0); // empty block ends the download
    check_status();
    end_test();

    start_test("error_recovery");
    out_request(8'h21, 8'd1, 16'd0, 16'd4);
    check_status();
    out_request(8'h21, 8'd1, 16'($urandom_range(64, 79)), 16'd4);
    check_status();
    out_request(8'h21, 8'd4, 16'd0, 16'd0);
    check_status();
    out_request(8'h21, 8'd1, 16'd0, 16'd4);
    out_request(8'h21, 8'd1, 16'd1, 16'd4); // no GETSTATUS in between
    check_status();
    out_request(8'h21, 8'd6, 16'd0, 16'd0);
    check_status();
    out_request(8'h21, 8'd4, 16'd0, 16'd0);
    check_status();
    end_test();

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/usb_dfu_ctrl_ep_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module usb_dfu_ctrl_ep_asserts (
  input wire logic       clk,
  input wire logic       reset,
  input wire logic       out_ep_data_get,
  input wire logic       out_ep_data_avail,
  input wire logic       in_ep_data_put,
  input wire logic       in_ep_data_free,
  input wire logic       in_ep_stall,
  input wire logic       in_ep_data_done,
  input wire logic [7:0] dfu_state
);

  a_get_needs_avail: assert property (@(posedge clk) disable iff (reset)
    out_ep_data_get |-> out_ep_data_avail)
    else $error("out_ep_data_get raised with no OUT data available");

  a_put_needs_free: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_put |-> in_ep_data_free)
    else $error("in_ep_data_put raised with no free IN buffer");

  a_stall_or_done: assert property (@(posedge clk) disable iff (reset)
    !(in_ep_stall && in_ep_data_done))
    else $error("in_ep_stall and in_ep_data_done high together");

  a_state_range: assert property (@(posedge clk) disable iff (reset)
    dfu_state <= 8'h0a) // dfu_error is the highest code
    else $error("dfu_state outside the DFU state codes");

endmodule

bind usb_dfu_ctrl_ep usb_dfu_ctrl_ep_asserts asserts_i (.*);

`default_nettype wire

//--- logic/usb_dfu_ctrl_ep.sv
`timescale 1ns/100ps
`default_nettype none

module usb_dfu_ctrl_ep #(
  parameter logic [15:0] vendor_id  = 16'h1d50,
  parameter logic [15:0] product_id = 16'h6130,
  parameter int unsigned max_packet = 32,
  parameter int unsigned max_block  = 64
) (
  input  logic       clk,
  input  logic       reset,

  // OUT endpoint
  output logic       out_ep_req,
  input  logic       out_ep_grant,
  input  logic       out_ep_data_avail,
  input  logic       out_ep_setup,
  output logic       out_ep_data_get,
  input  logic [7:0] out_ep_data,
  input  logic       out_ep_acked,

  // IN endpoint
  output logic       in_ep_req,
  input  logic       in_ep_grant,
  input  logic       in_ep_data_free,
  output logic       in_ep_data_put,
  output logic [7:0] in_ep_data,
  output logic       in_ep_data_done,
  output logic       in_ep_stall,
  input  logic       in_ep_acked,

  output logic [6:0] dev_addr,
  output logic [7:0] dfu_state
);

  setup_req_if req_if ();

  logic [15:0]              reply_len;
  logic                     stall_req;
  logic                     setup_stage_end;
  logic                     out_data_end;
  logic                     status_end;
  logic [7:0]               reply_addr;
  usb_dfu_pkg::reply_src_e  reply_src;
  usb_dfu_pkg::dfu_state_e  dfu_state_q;
  usb_dfu_pkg::dfu_status_e dfu_status;

  assign dfu_state = dfu_state_q;

  setup_capture setup_capture_i (
    .clk               (clk),
    .reset             (reset),
    .out_ep_setup      (out_ep_setup),
    .out_ep_data_avail (out_ep_data_avail),
    .out_ep_grant      (out_ep_grant),
    .out_ep_data       (out_ep_data),
    .req               (req_if.capture)
  );

  ctrl_xfr_fsm ctrl_xfr_fsm_i (
    .clk               (clk),
    .reset             (reset),
    .req               (req_if.fsm),
    .reply_len         (reply_len),
    .stall_req         (stall_req),
    .out_ep_data_avail (out_ep_data_avail),
    .out_ep_grant      (out_ep_grant),
    .out_ep_setup      (out_ep_setup),
    .in_ep_grant       (in_ep_grant),
    .in_ep_data_free   (in_ep_data_free),
    .in_ep_acked       (in_ep_acked),
    .out_ep_acked      (out_ep_acked),
    .out_ep_req        (out_ep_req),
    .out_ep_data_get   (out_ep_data_get),
    .in_ep_req         (in_ep_req),
    .in_ep_data_put    (in_ep_data_put),
    .in_ep_data_done   (in_ep_data_done),
    .in_ep_stall       (in_ep_stall),
    .setup_stage_end   (setup_stage_end),
    .out_data_end      (out_data_end),
    .status_end        (status_end),
    .reply_addr        (reply_addr)
  );

  dfu_request_handler #(
    .max_block (max_block)
  ) dfu_request_handler_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req_if.handler),
    .setup_stage_end (setup_stage_end),
    .out_data_end    (out_data_end),
    .status_end      (status_end),
    .reply_len       (reply_len),
    .stall_req       (stall_req),
    .reply_src       (reply_src),
    .dfu_state       (dfu_state_q),
    .dfu_status      (dfu_status),
    .dev_addr        (dev_addr)
  );

  reply_source #(
    .vendor_id  (vendor_id),
    .product_id (product_id),
    .max_packet (max_packet)
  ) reply_source_i (
    .reply_addr (reply_addr),
    .reply_src  (reply_src),
    .dfu_state  (dfu_state_q),
    .dfu_status (dfu_status),
    .in_ep_data (in_ep_data)
  );

endmodule

`default_nettype wire

//--- logic/reply_source.sv
`timescale 1ns/100ps
`default_nettype none

module reply_source #(
  parameter logic [15:0] vendor_id  = 16'h1d50,
  parameter logic [15:0] product_id = 16'h6130,
  parameter int unsigned max_packet = 32
) (
  input  logic [7:0]               reply_addr,
  input  usb_dfu_pkg::reply_src_e  reply_src,
  input  usb_dfu_pkg::dfu_state_e  dfu_state,
  input  usb_dfu_pkg::dfu_status_e dfu_status,
  output usb_dfu_pkg::byte_t       in_ep_data
);

  usb_dfu_pkg::byte_t desc_byte;
  usb_dfu_pkg::byte_t status_byte;

  // device descriptor
  always_comb begin
    case (reply_addr)
      8'd0:    desc_byte = 8'(usb_dfu_pkg::DEVICE_DESC_LEN);
      8'd1:    desc_byte = usb_dfu_pkg::DESC_DEVICE;
      8'd2:    desc_byte = 8'h00;              // bcdUSB 1.00
      8'd3:    desc_byte = 8'h01;
      8'd7:    desc_byte = 8'(max_packet);     // ep0 size
      8'd8:    desc_byte = vendor_id[7:0];
      8'd9:    desc_byte = vendor_id[15:8];
      8'd10:   desc_byte = product_id[7:0];
      8'd11:   desc_byte = product_id[15:8];
      8'd17:   desc_byte = 8'd1;               // one configuration
      default: desc_byte = 8'h00;              // class fields, bcdDevice, no strings
    endcase
  end

  // GETSTATUS record, GETSTATE starts at bState
  always_comb begin
    case (reply_addr)
      8'd0:                          status_byte = dfu_status;
      8'd1:                          status_byte = 8'd1; // poll timeout, 1 ms
      usb_dfu_pkg::DFU_STATE_OFFSET: status_byte = dfu_state;
      default:                       status_byte = 8'h00;
    endcase
  end

  assign in_ep_data = (reply_src == usb_dfu_pkg::dfu_status) ? status_byte : desc_byte;

endmodule

`default_nettype wire

//--- logic/dfu_request_handler.sv
`timescale 1ns/100ps
`default_nettype none

module dfu_request_handler #(
  parameter int unsigned max_block = 64
) (
  input  logic                     clk,
  input  logic                     reset,
  setup_req_if.handler             req,
  input  logic                     setup_stage_end,
  input  logic                     out_data_end,
  input  logic                     status_end,
  output logic [15:0]              reply_len,
  output logic                     stall_req,
  output usb_dfu_pkg::reply_src_e  reply_src,
  output usb_dfu_pkg::dfu_state_e  dfu_state,
  output usb_dfu_pkg::dfu_status_e dfu_status,
  output logic [6:0]               dev_addr
);

  logic        save_addr;  // address waits for the status stage
  logic [6:0]  new_addr;
  logic [15:0] block_end;  // first block past the download window

  //////////////////////////////////////////////////
  // request decode and DFU state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      reply_len  <= 16'd0;
      reply_src  <= usb_dfu_pkg::descriptor;
      stall_req  <= 1'b0;
      dfu_state  <= usb_dfu_pkg::dfu_idle;
      dfu_status <= usb_dfu_pkg::ok;
      save_addr  <= 1'b0;
      dev_addr   <= 7'd0;
    end else begin
      stall_req <= 1'b0;

      if (status_end && save_addr) begin
        save_addr <= 1'b0;
        dev_addr  <= new_addr;
      end

      // end of the data stage stands in for the write finishing
      if (out_data_end && dfu_state == usb_dfu_pkg::dnbusy) begin
        dfu_state <= usb_dfu_pkg::dnload_sync;
      end

      if (setup_stage_end) begin
        reply_len <= 16'd0;
        reply_src <= usb_dfu_pkg::descriptor;

        case (req.request)
          usb_dfu_pkg::get_descriptor: begin
            if (req.value[15:8] == usb_dfu_pkg::DESC_DEVICE) begin
              reply_len <= 16'(usb_dfu_pkg::DEVICE_DESC_LEN);
            end else begin
              stall_req <= 1'b1; // only the device descriptor exists
            end
          end
          usb_dfu_pkg::set_address: save_addr <= 1'b1;
          usb_dfu_pkg::set_configuration, usb_dfu_pkg::set_interface: begin
            // single config, single setting
          end
          usb_dfu_pkg::dnload: begin
            if (dfu_state == usb_dfu_pkg::dfu_idle) begin
              if (req.length != 16'd0) begin
                dfu_state <= usb_dfu_pkg::dnbusy;
              end else begin
                dfu_state  <= usb_dfu_pkg::dfu_error;
                dfu_status <= usb_dfu_pkg::err_write;
              end
            end else if (dfu_state != usb_dfu_pkg::dnload_idle) begin
              dfu_state  <= usb_dfu_pkg::dfu_error; // not ready for a block
              dfu_status <= usb_dfu_pkg::err_write;
            end else if (req.length == 16'd0) begin
              dfu_state <= usb_dfu_pkg::manifest_sync; // final empty block
            end else if (req.value >= block_end) begin
              dfu_state  <= usb_dfu_pkg::dfu_error;
              dfu_status <= usb_dfu_pkg::err_address;
            end else begin
              dfu_state <= usb_dfu_pkg::dnbusy;
            end
          end
          usb_dfu_pkg::getstatus: begin
            reply_src <= usb_dfu_pkg::dfu_status;
            reply_len <= 16'(usb_dfu_pkg::DFU_STATUS_LEN);
            if (dfu_state == usb_dfu_pkg::dnload_sync) begin
              dfu_state <= usb_dfu_pkg::dnload_idle;
            end else if (dfu_state == usb_dfu_pkg::manifest_sync) begin
              dfu_state <= usb_dfu_pkg::dfu_idle;
            end
          end
          usb_dfu_pkg::clrstatus: begin
            dfu_status <= usb_dfu_pkg::ok;
            dfu_state  <= usb_dfu_pkg::dfu_idle;
          end
          usb_dfu_pkg::getstate: begin
            reply_src <= usb_dfu_pkg::dfu_status; // bState byte only
            reply_len <= 16'd1;
          end
          usb_dfu_pkg::abort: dfu_state <= usb_dfu_pkg::dfu_idle;
          default: begin
            // unknown requests are acked with no data
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_stage_end) begin
      if (req.request == usb_dfu_pkg::set_address) begin
        new_addr <= req.value[6:0];
      end
      if (req.request == usb_dfu_pkg::dnload && dfu_state == usb_dfu_pkg::dfu_idle) begin
        block_end <= req.value + 16'(max_block); // window opens at the first block
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ctrl_xfr_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_xfr_fsm (
  input  logic        clk,
  input  logic        reset,
  setup_req_if.fsm    req,
  input  logic [15:0] reply_len,
  input  logic        stall_req,
  input  logic        out_ep_data_avail,
  input  logic        out_ep_grant,
  input  logic        out_ep_setup,
  input  logic        in_ep_grant,
  input  logic        in_ep_data_free,
  input  logic        in_ep_acked,
  input  logic        out_ep_acked,
  output logic        out_ep_req,
  output logic        out_ep_data_get,
  output logic        in_ep_req,
  output logic        in_ep_data_put,
  output logic        in_ep_data_done,
  output logic        in_ep_stall,
  output logic        setup_stage_end,
  output logic        out_data_end,
  output logic        status_end,
  output logic [7:0]  reply_addr
);

  usb_dfu_pkg::ctrl_state_e state;
  usb_dfu_pkg::ctrl_state_e state_next;

  logic [15:0] byte_cnt;     // bytes moved in this data stage
  logic [15:0] xfer_len;
  logic        all_sent;
  logic        all_sent_q;
  logic        zero_len_pkt;
  logic        in_taken;
  logic        out_taken;

  // OUT side simply drains whatever the endpoint has
  assign out_ep_req      = out_ep_data_avail;
  assign out_ep_data_get = out_ep_data_avail;

  assign xfer_len = (reply_len < req.length) ? reply_len : req.length;
  assign all_sent = (state == usb_dfu_pkg::data_in) && (byte_cnt == xfer_len);

  assign in_ep_req      = (state == usb_dfu_pkg::data_in) && !all_sent;
  assign in_ep_data_put = in_ep_req && in_ep_data_free;
  assign in_taken       = in_ep_grant && in_ep_data_put;
  assign out_taken      = (state == usb_dfu_pkg::data_out) && out_ep_grant && out_ep_data_get;

  assign in_ep_stall     = stall_req;
  assign in_ep_data_done = zero_len_pkt || (all_sent && !all_sent_q && !stall_req);

  //////////////////////////////////////////////////
  // stage sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_next      = state;
    setup_stage_end = 1'b0;
    out_data_end    = 1'b0;
    status_end      = 1'b0;
    zero_len_pkt    = 1'b0;

    case (state)
      usb_dfu_pkg::idle: begin
        if (out_ep_setup && out_ep_data_avail) state_next = usb_dfu_pkg::setup_in;
      end
      usb_dfu_pkg::setup_in: begin
        if (req.setup_done) state_next = usb_dfu_pkg::setup_done;
      end
      usb_dfu_pkg::setup_done: begin
        setup_stage_end = 1'b1;
        if (req.length == 16'd0) begin
          state_next   = usb_dfu_pkg::status_in;
          zero_len_pkt = 1'b1; // status stage answered with a ZLP
        end else if (req.request_type[7]) begin
          state_next = usb_dfu_pkg::data_in;
        end else begin
          state_next = usb_dfu_pkg::data_out;
        end
      end
      usb_dfu_pkg::data_in: begin
        if (in_ep_acked && all_sent) state_next = usb_dfu_pkg::status_out;
      end
      usb_dfu_pkg::data_out: begin
        if (byte_cnt == req.length) begin
          state_next   = usb_dfu_pkg::status_in;
          zero_len_pkt = 1'b1;
          out_data_end = 1'b1;
        end
      end
      usb_dfu_pkg::status_in: begin
        if (in_ep_acked) begin
          state_next = usb_dfu_pkg::idle;
          status_end = 1'b1;
        end
      end
      usb_dfu_pkg::status_out: begin
        if (out_ep_acked) begin
          state_next = usb_dfu_pkg::idle;
          status_end = 1'b1;
        end
      end
      default: state_next = usb_dfu_pkg::idle;
    endcase

    // a stalled request abandons the transfer
    if (stall_req) state_next = usb_dfu_pkg::idle;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= usb_dfu_pkg::idle;
      all_sent_q <= 1'b0;
      byte_cnt   <= 16'd0;
      reply_addr <= 8'd0;
    end else begin
      state      <= state_next;
      all_sent_q <= all_sent;
      if (setup_stage_end) begin
        byte_cnt   <= 16'd0;
        reply_addr <= (req.request == usb_dfu_pkg::getstate) ?
                      usb_dfu_pkg::DFU_STATE_OFFSET : 8'd0;
      end else if (in_taken || out_taken) begin
        byte_cnt   <= byte_cnt + 16'd1;
        reply_addr <= reply_addr + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/setup_capture.sv
`timescale 1ns/100ps
`default_nettype none

module setup_capture (
  input  logic               clk,
  input  logic               reset,
  input  logic               out_ep_setup,
  input  logic               out_ep_data_avail,
  input  logic               out_ep_grant,
  input  usb_dfu_pkg::byte_t out_ep_data,
  setup_req_if.capture       req
);

  usb_dfu_pkg::byte_t setup_bytes [8];
  logic [2:0]         wr_ptr;
  logic               byte_valid; // out_ep_data holds a granted byte
  logic               avail_q;
  logic               in_setup;
  logic               pkt_end;

  assign pkt_end = avail_q && !out_ep_data_avail;

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q         <= 1'b0;
      byte_valid      <= 1'b0;
      in_setup        <= 1'b0;
      wr_ptr          <= 3'd0;
      req.setup_done  <= 1'b0;
    end else begin
      avail_q        <= out_ep_data_avail;
      byte_valid     <= out_ep_data_avail && out_ep_grant;
      req.setup_done <= pkt_end && in_setup;

      if (pkt_end) begin
        in_setup <= 1'b0;
      end else if (out_ep_data_avail && out_ep_setup) begin
        in_setup <= 1'b1;
      end

      if (pkt_end) begin
        wr_ptr <= 3'd0; // ready for the next setup packet
      end else if (in_setup && byte_valid) begin
        wr_ptr <= wr_ptr + 3'd1;
      end
    end
  end

  // last byte lands on the pkt_end cycle, before setup_done
  always_ff @(posedge clk) begin
    if (in_setup && byte_valid) begin
      setup_bytes[wr_ptr] <= out_ep_data;
    end
  end

  assign req.request_type = setup_bytes[0];
  assign req.request      = usb_dfu_pkg::request_e'({setup_bytes[0][6:5], setup_bytes[1]});
  assign req.value        = {setup_bytes[3], setup_bytes[2]};
  assign req.length       = {setup_bytes[7], setup_bytes[6]}; // wIndex not needed

endmodule

`default_nettype wire

//--- logic/setup_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface setup_req_if;

  logic                  setup_done;   // one cycle, fields valid from here
  usb_dfu_pkg::byte_t    request_type;
  usb_dfu_pkg::request_e request;
  logic [15:0]           value;
  logic [15:0]           length;

  modport capture (
    output setup_done, request_type, request, value, length
  );

  modport handler (
    input request, value, length
  );

  modport fsm (
    input setup_done, request_type, request, length
  );

endinterface

`default_nettype wire

//--- logic/usb_dfu_pkg.sv
`default_nettype none

package usb_dfu_pkg;

  typedef logic [7:0] byte_t;

  // control transfer stages
  typedef enum logic [2:0] {
    idle,
    setup_in,
    setup_done,
    data_in,
    data_out,
    status_in,
    status_out
  } ctrl_state_e;

  // standard DFU 1.1 state codes
  typedef enum logic [7:0] {
    app_idle            = 8'h00,
    app_detach          = 8'h01,
    dfu_idle            = 8'h02,
    dnload_sync         = 8'h03,
    dnbusy              = 8'h04,
    dnload_idle         = 8'h05,
    manifest_sync       = 8'h06,
    manifest            = 8'h07,
    manifest_wait_reset = 8'h08,
    upload_idle         = 8'h09,
    dfu_error           = 8'h0a
  } dfu_state_e;

  typedef enum logic [7:0] {
    ok          = 8'h00,
    err_write   = 8'h03,
    err_address = 8'h08
  } dfu_status_e;

  // {bmRequestType[6:5], bRequest}
  typedef enum logic [9:0] {
    set_address       = 10'h005,
    get_descriptor    = 10'h006,
    set_configuration = 10'h009,
    set_interface     = 10'h00b,
    dnload            = 10'h101,
    getstatus         = 10'h103,
    clrstatus         = 10'h104,
    getstate          = 10'h105,
    abort             = 10'h106
  } request_e;

  typedef enum logic {
    descriptor,
    dfu_status
  } reply_src_e;

  localparam logic [7:0]  DESC_DEVICE      = 8'd1;
  localparam int unsigned DEVICE_DESC_LEN  = 18;
  localparam int unsigned DFU_STATUS_LEN   = 6;
  localparam logic [7:0]  DFU_STATE_OFFSET = 8'd4; // bState within the status record

endpackage

`default_nettype wire
